//--- include/core_cfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// data and address width in bits.
`define CORE_DATA_W 32

// number of general registers with one flag each.
`define CORE_NREGS 8

// word address of the first instruction.
`define CORE_RESET_PC 32'd0

`endif

//--- source/core_pkg.sv
package core_pkg;

    `include "core_cfg.svh"

    typedef logic [`CORE_DATA_W-1:0] word_t;
    typedef logic [$clog2(`CORE_NREGS)-1:0] reg_idx_t;

    typedef enum logic [6:0]
    {
        OP_ADD   = 7'd1,
        OP_SUB   = 7'd2,
        OP_AND   = 7'd3,
        OP_OR    = 7'd4,
        OP_XOR   = 7'd5,
        OP_LDI   = 7'd6,
        OP_LOAD  = 7'd7,
        OP_STORE = 7'd8,
        OP_BRZ   = 7'd9,
        OP_JMP   = 7'd10,
        OP_HALT  = 7'd11
    } opcode_e;

    // fields are listed high to low so opcode sits in bits 6:0.
    typedef struct packed
    {
        logic [15:0] imm;
        reg_idx_t    rd;
        reg_idx_t    rb;
        reg_idx_t    ra;
        opcode_e     opcode;
    } instr_t;

    typedef struct packed
    {
        word_t addr;
        logic  we;
        word_t wdata;
    } mem_req_t;

    typedef struct packed
    {
        word_t value;
        logic  zero;
    } alu_result_t;

    typedef struct packed
    {
        logic     en;
        reg_idx_t idx;
        word_t    value;
        logic     flag;
    } reg_write_t;

endpackage

//--- source/core_alu.sv
module core_alu
    import core_pkg::*;
(
    input  opcode_e     op,
    input  word_t       a,
    input  word_t       b,
    output alu_result_t result
);

    word_t value;

    // arithmetic wraps at the word width.
    always_comb
    begin
        case (op)
            OP_ADD:
            begin
                value = a + b;
            end
            OP_SUB:
            begin
                value = a - b;
            end
            OP_AND:
            begin
                value = a & b;
            end
            OP_OR:
            begin
                value = a | b;
            end
            OP_XOR:
            begin
                value = a ^ b;
            end
            default:
            begin
                value = '0;
            end
        endcase
    end

    always_comb
    begin
        result.value = value;
        result.zero  = (value == '0);
    end

endmodule

//--- source/core_regfile.sv
module core_regfile
    import core_pkg::*;
(
    input  logic       clock,
    input  logic       rst_n,
    input  reg_idx_t   ra_idx,
    input  reg_idx_t   rb_idx,
    output word_t      ra_value,
    output word_t      rb_value,
    output logic       ra_flag,
    input  reg_write_t write
);

    `include "core_cfg.svh"

    word_t regs  [`CORE_NREGS];
    logic  flags [`CORE_NREGS];

    // value and flag are always written as a pair.
    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < `CORE_NREGS; i++)
            begin
                regs[i]  <= '0;
                flags[i] <= 1'b0;
            end
        end
        else if (write.en)
        begin
            regs[write.idx]  <= write.value;
            flags[write.idx] <= write.flag;
        end
    end

    // reads see the value stored before this edge.
    always_comb
    begin
        ra_value = regs[ra_idx];
        rb_value = regs[rb_idx];
        ra_flag  = flags[ra_idx];
    end

endmodule

//--- source/mem_port.sv
module mem_port
    import core_pkg::*;
(
    input  logic     clock,
    input  logic     rst_n,
    input  logic     start,
    input  mem_req_t request,
    output logic     done,
    output word_t    rdata,
    output mem_req_t mem_req,
    output logic     mem_req_valid,
    input  logic     mem_ack,
    input  word_t    mem_rdata
);

    typedef enum logic [1:0]
    {
        P_IDLE,
        P_REQ,
        P_RELEASE
    } port_state_e;

    port_state_e state;

    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            state <= P_IDLE;
            done  <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            case (state)
                P_IDLE:
                begin
                    if (start)
                        state <= P_REQ;
                end
                P_REQ:
                begin
                    if (mem_ack)
                        state <= P_RELEASE;
                end
                P_RELEASE:
                begin
                    // wait for ack low so the next req starts clean.
                    if (!mem_ack)
                    begin
                        state <= P_IDLE;
                        done  <= 1'b1;
                    end
                end
                default:
                begin
                    state <= P_IDLE;
                end
            endcase
        end
    end

    // request held here so the bus stays stable while req is up.
    always_ff @(posedge clock)
    begin
        if (state == P_IDLE && start)
            mem_req <= request;
        if (state == P_REQ && mem_ack)
            rdata <= mem_rdata;
    end

    assign mem_req_valid = (state == P_REQ);

endmodule

//--- source/core_control.sv
module core_control
    import core_pkg::*;
(
    input  logic        clock,
    input  logic        rst_n,
    output logic        mem_start,
    output mem_req_t    mem_request,
    input  logic        mem_done,
    input  word_t       mem_word,
    output reg_idx_t    ra_idx,
    output reg_idx_t    rb_idx,
    input  word_t       ra_value,
    input  word_t       rb_value,
    input  logic        ra_flag,
    output opcode_e     alu_op,
    input  alu_result_t alu_out,
    output reg_write_t  reg_write,
    output logic        halted
);

    `include "core_cfg.svh"

    typedef enum logic [1:0]
    {
        S_FETCH,
        S_EXEC,
        S_MEM,
        S_HALT
    } state_e;

    state_e state;
    word_t  pc;
    word_t  pc_next;
    word_t  imm_word;
    instr_t ir;
    logic   fetch_sent;

    assign pc_next  = pc + word_t'(1);
    assign imm_word = word_t'(ir.imm);

    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            state      <= S_FETCH;
            pc         <= `CORE_RESET_PC;
            fetch_sent <= 1'b0;
        end
        else
        begin
            case (state)
                S_FETCH:
                begin
                    if (mem_done)
                    begin
                        fetch_sent <= 1'b0;
                        state      <= S_EXEC;
                    end
                    else
                    begin
                        fetch_sent <= 1'b1;
                    end
                end
                S_EXEC:
                begin
                    case (ir.opcode)
                        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_LDI:
                        begin
                            pc    <= pc_next;
                            state <= S_FETCH;
                        end
                        OP_LOAD, OP_STORE:
                        begin
                            state <= S_MEM;
                        end
                        OP_BRZ:
                        begin
                            pc    <= ra_flag ? imm_word : pc_next;
                            state <= S_FETCH;
                        end
                        OP_JMP:
                        begin
                            pc    <= imm_word;
                            state <= S_FETCH;
                        end
                        default:
                        begin
                            // HALT and any unknown opcode.
                            state <= S_HALT;
                        end
                    endcase
                end
                S_MEM:
                begin
                    if (mem_done)
                    begin
                        pc    <= pc_next;
                        state <= S_FETCH;
                    end
                end
                default:
                begin
                    state <= S_HALT;
                end
            endcase
        end
    end

    always_ff @(posedge clock)
    begin
        if (state == S_FETCH && mem_done)
            ir <= instr_t'(mem_word);
    end

    assign ra_idx = ir.ra;
    assign rb_idx = ir.rb;
    assign alu_op = ir.opcode;
    assign halted = (state == S_HALT);

    always_comb
    begin
        mem_start         = 1'b0;
        mem_request.addr  = pc;
        mem_request.we    = 1'b0;
        mem_request.wdata = '0;
        reg_write.en      = 1'b0;
        reg_write.idx     = ir.rd;
        reg_write.value   = alu_out.value;
        reg_write.flag    = alu_out.zero;

        if (state == S_FETCH)
        begin
            mem_start = !fetch_sent;
        end
        else if (state == S_EXEC)
        begin
            mem_request.addr  = ra_value + imm_word;
            mem_request.we    = (ir.opcode == OP_STORE);
            mem_request.wdata = rb_value;
            case (ir.opcode)
                OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR:
                begin
                    reg_write.en = 1'b1;
                end
                OP_LDI:
                begin
                    reg_write.en    = 1'b1;
                    reg_write.value = imm_word;
                    reg_write.flag  = (imm_word == '0);
                end
                OP_LOAD, OP_STORE:
                begin
                    mem_start = 1'b1;
                end
                default:
                begin
                    mem_start = 1'b0;
                end
            endcase
        end
        else if (state == S_MEM && mem_done && ir.opcode == OP_LOAD)
        begin
            // load write-back lands in the done cycle.
            reg_write.en    = 1'b1;
            reg_write.value = mem_word;
            reg_write.flag  = (mem_word == '0);
        end
    end

endmodule

//--- source/core_top.sv
module core_top
    import core_pkg::*;
(
    input  logic     clock,
    input  logic     rst_n,
    output mem_req_t mem_req,
    output logic     mem_req_valid,
    input  logic     mem_ack,
    input  word_t    mem_rdata,
    output logic     halted
);

    logic        mem_start;
    mem_req_t    mem_request;
    logic        mem_done;
    word_t       mem_word;
    reg_idx_t    ra_idx;
    reg_idx_t    rb_idx;
    word_t       ra_value;
    word_t       rb_value;
    logic        ra_flag;
    opcode_e     alu_op;
    alu_result_t alu_out;
    reg_write_t  reg_write;

    core_control u_control (
        .clock       (clock),
        .rst_n       (rst_n),
        .mem_start   (mem_start),
        .mem_request (mem_request),
        .mem_done    (mem_done),
        .mem_word    (mem_word),
        .ra_idx      (ra_idx),
        .rb_idx      (rb_idx),
        .ra_value    (ra_value),
        .rb_value    (rb_value),
        .ra_flag     (ra_flag),
        .alu_op      (alu_op),
        .alu_out     (alu_out),
        .reg_write   (reg_write),
        .halted      (halted)
    );

    core_alu u_alu (
        .op     (alu_op),
        .a      (ra_value),
        .b      (rb_value),
        .result (alu_out)
    );

    core_regfile u_regfile (
        .clock    (clock),
        .rst_n    (rst_n),
        .ra_idx   (ra_idx),
        .rb_idx   (rb_idx),
        .ra_value (ra_value),
        .rb_value (rb_value),
        .ra_flag  (ra_flag),
        .write    (reg_write)
    );

    mem_port u_mem_port (
        .clock         (clock),
        .rst_n         (rst_n),
        .start         (mem_start),
        .request       (mem_request),
        .done          (mem_done),
        .rdata         (mem_word),
        .mem_req       (mem_req),
        .mem_req_valid (mem_req_valid),
        .mem_ack       (mem_ack),
        .mem_rdata     (mem_rdata)
    );

endmodule

//--- dv/core_asserts.sv
module core_asserts
    import core_pkg::*;
(
    input logic     clock,
    input logic     rst_n,
    input mem_req_t mem_req,
    input logic     mem_req_valid,
    input logic     mem_ack,
    input logic     halted
);

    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    // the request bus holds while req is up.
    request_stable: assert property (@(posedge clock) disable iff (!rst_n)
        mem_req_valid && $past(mem_req_valid) |-> $stable(mem_req))
    else
    begin
        fail_count++;
        $error("memory request changed while req was high");
    end

    req_after_ack_low: assert property (@(posedge clock) disable iff (!rst_n)
        $rose(mem_req_valid) |-> !$past(mem_ack))
    else
    begin
        fail_count++;
        $error("req rose while ack was still high");
    end

    halt_sticky: assert property (@(posedge clock) disable iff (!rst_n)
        halted |=> halted)
    else
    begin
        fail_count++;
        $error("halted dropped without a reset");
    end

    req_low_after_reset: assert property (@(posedge clock)
        !rst_n |=> !mem_req_valid)
    else
    begin
        fail_count++;
        $error("req was high right after a reset cycle");
    end

endmodule

//--- dv/tb_core.sv
module tb_core
    import core_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    `include "core_cfg.svh"

    localparam int MEM_WORDS       = 256;
    localparam int SHORT_DELAY     = 5;
    localparam int LONG_DELAY      = 10;
    localparam int TEST_COUNT      = 6;
    localparam int LONGEST_PROGRAM = 16;
    // a load or store instruction costs two handshakes with two waits each.
    localparam int WORST_HANDSHAKE = 2 * LONG_DELAY + 1;
    localparam int WATCHDOG_CYCLES = TEST_COUNT * LONGEST_PROGRAM * 2 * WORST_HANDSHAKE;

    logic     clock = 1'b0;
    logic     rst_n;
    mem_req_t mem_req;
    logic     mem_req_valid;
    logic     mem_ack;
    word_t    mem_rdata;
    logic     halted;

    word_t       mem [MEM_WORDS];
    word_t       prog [$];
    mem_req_t    store_log [$];
    int          req_count = 0;
    word_t       first_addr;
    int          max_delay = SHORT_DELAY;
    logic [31:0] lcg_state = 32'd56;
    int          value_errors = 0;
    int          other_errors = 0;

    core_top i_dut (
        .clock         (clock),
        .rst_n         (rst_n),
        .mem_req       (mem_req),
        .mem_req_valid (mem_req_valid),
        .mem_ack       (mem_ack),
        .mem_rdata     (mem_rdata),
        .halted        (halted)
    );

    bind core_top core_asserts i_asserts (.*);

    always #4 clock = ~clock;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [15:0] random_half();
        logic [31:0] r;
        r = lcg_next();
        return r[31:16];
    endfunction

    function automatic int ack_delay();
        logic [31:0] r;
        r = lcg_next();
        return int'(r[31:16]) % (max_delay + 1);
    endfunction

    // background word, different at every address.
    function automatic word_t fill_word(int addr);
        return {16'hc0de, 8'(addr), ~8'(addr)};
    endfunction

    task automatic append_instr(opcode_e op, int rd, int ra, int rb, int imm);
        instr_t ins;
        ins.opcode = op;
        ins.ra     = reg_idx_t'(ra);
        ins.rb     = reg_idx_t'(rb);
        ins.rd     = reg_idx_t'(rd);
        ins.imm    = 16'(imm);
        prog.push_back(word_t'(ins));
    endtask

    task automatic check_word(string name, word_t expected, word_t actual);
        if (actual !== expected)
        begin
            value_errors++;
            $display("Error: %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_bit(string name, logic expected, logic actual);
        if (actual !== expected)
        begin
            value_errors++;
            $display("Error: %s expected %b actual %b", name, expected, actual);
        end
    endtask

    task automatic check_req(string name, mem_req_t expected, mem_req_t actual);
        if (actual !== expected)
        begin
            value_errors++;
            $display("Error: %s expected addr %h we %b wdata %h actual addr %h we %b wdata %h",
                     name, expected.addr, expected.we, expected.wdata,
                     actual.addr, actual.we, actual.wdata);
        end
    endtask

    task automatic serve_request();
        int addr;
        addr = int'(mem_req.addr);
        req_count++;
        if (req_count == 1)
            first_addr = mem_req.addr;
        if (mem_req.addr >= MEM_WORDS)
        begin
            other_errors++;
            $display("memory request to address %h is outside the model", mem_req.addr);
            mem_rdata = '0;
        end
        else if (mem_req.we)
        begin
            mem[addr] = mem_req.wdata;
            store_log.push_back(mem_req);
        end
        else
            mem_rdata = mem[addr];
    endtask

    // four-phase responder where both ack edges wait a random number of cycles.
    initial
    begin : memory_model
        int delay;
        mem_ack   = 1'b0;
        mem_rdata = '0;
        forever
        begin
            @(posedge clock);
            #1;
            if (rst_n && mem_req_valid && !mem_ack)
            begin
                delay = ack_delay();
                repeat (delay)
                begin
                    @(posedge clock);
                    #1;
                end
                serve_request();
                mem_ack = 1'b1;
                while (mem_req_valid)
                begin
                    @(posedge clock);
                    #1;
                end
                delay = ack_delay();
                repeat (delay)
                begin
                    @(posedge clock);
                    #1;
                end
                mem_ack = 1'b0;
            end
        end
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

    task automatic load_program();
        for (int i = 0; i < MEM_WORDS; i++)
            mem[i] = fill_word(i);
        foreach (prog[i])
            mem[i] = prog[i];
    endtask

    task automatic reset_core();
        @(posedge clock);
        #1;
        rst_n = 1'b0;
        req_count = 0;
        store_log.delete();
        repeat (8) @(posedge clock);
        #1;
        rst_n = 1'b1;
    endtask

    task automatic wait_for_halt();
        while (!halted)
        begin
            @(posedge clock);
            #1;
        end
    endtask

    task automatic run_core();
        reset_core();
        wait_for_halt();
    endtask

    task automatic test_reset();
        prog.delete();
        append_instr(OP_HALT, 0, 0, 0, 0);
        load_program();
        reset_core();
        check_bit("reset req", 1'b0, mem_req_valid);
        check_bit("reset halted", 1'b0, halted);
        wait_for_halt();
        check_word("reset first fetch", `CORE_RESET_PC, first_addr);
        check_word("reset fetch count", 32'd1, word_t'(req_count));
    endtask

    task automatic test_arithmetic();
        opcode_e ops [5];
        word_t   expected [5];
        word_t   a;
        word_t   b;
        ops = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR};
        for (int round = 0; round < 3; round++)
        begin
            a = word_t'(random_half());
            // the last round has equal operands so SUB lands on zero.
            b = (round == 2) ? a : word_t'(random_half());
            expected[0] = a + b;
            expected[1] = a - b;
            expected[2] = a & b;
            expected[3] = a | b;
            expected[4] = a ^ b;
            prog.delete();
            append_instr(OP_LDI, 1, 0, 0, a);
            append_instr(OP_LDI, 2, 0, 0, b);
            for (int k = 0; k < 5; k++)
            begin
                append_instr(ops[k], 3, 1, 2, 0);
                append_instr(OP_STORE, 0, 0, 3, 100 + k);
            end
            append_instr(OP_HALT, 0, 0, 0, 0);
            load_program();
            run_core();
            for (int k = 0; k < 5; k++)
                check_word($sformatf("arith %s round %0d", ops[k].name(), round),
                           expected[k], mem[100 + k]);
        end
    endtask

    task automatic test_load_store();
        word_t    v;
        word_t    w;
        mem_req_t expected;
        v = word_t'(random_half());
        w = lcg_next();
        prog.delete();
        append_instr(OP_LDI, 1, 0, 0, 40);
        append_instr(OP_LDI, 2, 0, 0, v);
        append_instr(OP_STORE, 0, 1, 2, 5);
        append_instr(OP_LOAD, 3, 1, 0, 5);
        append_instr(OP_STORE, 0, 0, 3, 120);
        append_instr(OP_LOAD, 4, 0, 0, 60);
        append_instr(OP_STORE, 0, 0, 4, 121);
        append_instr(OP_HALT, 0, 0, 0, 0);
        load_program();
        mem[60] = w;
        run_core();
        if (store_log.size() != 3)
        begin
            other_errors++;
            $display("load and store test saw %0d stores instead of 3", store_log.size());
        end
        else
        begin
            expected.addr  = 32'd45;
            expected.we    = 1'b1;
            expected.wdata = v;
            check_req("store to ra plus imm", expected, store_log[0]);
            expected.addr  = 32'd120;
            check_req("store of loaded word", expected, store_log[1]);
        end
        check_word("loaded word", v, mem[120]);
        check_word("full width load", w, mem[121]);
    endtask

    task automatic test_branch();
        word_t x;
        word_t marker;
        for (int equal = 1; equal >= 0; equal--)
        begin
            x = word_t'(random_half());
            prog.delete();
            append_instr(OP_LDI, 1, 0, 0, x);
            append_instr(OP_LDI, 2, 0, 0, equal ? x : x + 1);
            append_instr(OP_LDI, 4, 0, 0, 16'h1234);
            append_instr(OP_SUB, 3, 1, 2, 0);
            append_instr(OP_BRZ, 0, 3, 0, 6);
            append_instr(OP_STORE, 0, 0, 4, 130);
            append_instr(OP_HALT, 0, 0, 0, 0);
            load_program();
            run_core();
            marker = equal ? fill_word(130) : 32'h1234;
            check_word($sformatf("branch equal=%0d", equal), marker, mem[130]);
        end
    endtask

    task automatic test_back_pressure();
        mem_req_t ref_log [$];
        word_t    ref_data [4];
        word_t    a;
        word_t    b;
        word_t    w;
        a = word_t'(random_half());
        b = word_t'(random_half());
        w = lcg_next();
        prog.delete();
        append_instr(OP_LDI, 1, 0, 0, a);
        append_instr(OP_LDI, 2, 0, 0, b);
        append_instr(OP_ADD, 3, 1, 2, 0);
        append_instr(OP_STORE, 0, 0, 3, 100);
        append_instr(OP_XOR, 4, 1, 2, 0);
        append_instr(OP_STORE, 0, 0, 4, 101);
        append_instr(OP_LOAD, 5, 0, 0, 60);
        append_instr(OP_SUB, 6, 5, 1, 0);
        append_instr(OP_STORE, 0, 0, 6, 102);
        append_instr(OP_LOAD, 7, 0, 0, 100);
        append_instr(OP_STORE, 0, 0, 7, 103);
        append_instr(OP_HALT, 0, 0, 0, 0);
        for (int pass = 0; pass < 2; pass++)
        begin
            max_delay = (pass == 0) ? 0 : LONG_DELAY;
            load_program();
            mem[60] = w;
            run_core();
            if (pass == 0)
            begin
                ref_log = store_log;
                for (int i = 0; i < 4; i++)
                    ref_data[i] = mem[100 + i];
            end
        end
        max_delay = SHORT_DELAY;
        check_word("zero delay sum", a + b, ref_data[0]);
        check_word("zero delay difference", w - a, ref_data[2]);
        if (store_log.size() != ref_log.size())
        begin
            other_errors++;
            $display("slow memory run made %0d stores, fast run made %0d",
                     store_log.size(), ref_log.size());
        end
        else
        begin
            foreach (ref_log[i])
                check_req($sformatf("slow store %0d", i), ref_log[i], store_log[i]);
        end
        for (int i = 0; i < 4; i++)
            check_word($sformatf("slow result %0d", i), ref_data[i], mem[100 + i]);
    endtask

    task automatic test_halt_jump();
        int count;
        prog.delete();
        append_instr(OP_LDI, 1, 0, 0, 16'h77);
        append_instr(OP_JMP, 0, 0, 0, 3);
        append_instr(OP_STORE, 0, 0, 1, 140);
        append_instr(OP_STORE, 0, 0, 1, 141);
        append_instr(OP_HALT, 0, 0, 0, 0);
        append_instr(OP_STORE, 0, 0, 1, 142);
        load_program();
        run_core();
        count = req_count;
        repeat (20) @(posedge clock);
        #1;
        check_word("jump skips store", fill_word(140), mem[140]);
        check_word("store after jump", 32'h77, mem[141]);
        check_word("nothing after halt", fill_word(142), mem[142]);
        check_word("requests after halt", word_t'(count), word_t'(req_count));
        check_bit("req low after halt", 1'b0, mem_req_valid);
        check_bit("halted stays high", 1'b1, halted);
    endtask

    initial
    begin
        rst_n = 1'b0;
        test_reset();
        test_arithmetic();
        test_load_store();
        test_branch();
        test_back_pressure();
        test_halt_jump();
        $display("value errors %0d, other errors %0d, assertion failures %0d",
                 value_errors, other_errors, i_dut.i_asserts.fail_count);
        if (value_errors == 0 && other_errors == 0 && i_dut.i_asserts.fail_count == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

//--- all.f
+incdir+include
source/core_pkg.sv
source/core_alu.sv
source/core_regfile.sv
source/mem_port.sv
source/core_control.sv
source/core_top.sv
dv/core_asserts.sv
dv/tb_core.sv
